/* hw/sprite_pkg.sv */
package sprite_pkg;

    // the register map has one x register per sprite, so the count is fixed
    localparam int NUM_SPRITES = 8;

    // three data bytes make up one sprite line
    localparam int SPRITE_BITS = 24;
    localparam int XPOS_WIDTH = 9;

    typedef logic [NUM_SPRITES-1:0] sprite_mask_t;

    // one 2-bit pixel code per sprite, where code 0 is transparent
    typedef logic [NUM_SPRITES-1:0][1:0] sprite_pixels_t;

    typedef logic [XPOS_WIDTH-1:0] sprite_xpos_t;

    // side information that travels down the delay line with each pixel
    typedef struct packed {
        sprite_mask_t mmc;
        logic         act_valid;
        logic [2:0]   act_num;
    } sprite_tag_t;

    // register indices as decoded from address bits 5 to 2
    localparam logic [3:0] REG_X0 = 4'd0;
    localparam logic [3:0] REG_X1 = 4'd1;
    localparam logic [3:0] REG_X2 = 4'd2;
    localparam logic [3:0] REG_X3 = 4'd3;
    localparam logic [3:0] REG_X4 = 4'd4;
    localparam logic [3:0] REG_X5 = 4'd5;
    localparam logic [3:0] REG_X6 = 4'd6;
    localparam logic [3:0] REG_X7 = 4'd7;
    localparam logic [3:0] REG_XMSB = 4'd8;
    localparam logic [3:0] REG_EN = 4'd9;
    localparam logic [3:0] REG_XE = 4'd10;
    localparam logic [3:0] REG_MMC = 4'd11;
    localparam logic [3:0] REG_M2M = 4'd12;
    localparam logic [3:0] REG_M2D = 4'd13;
    localparam logic [3:0] REG_IRQ = 4'd14;

    // flag positions inside the interrupt register
    localparam int IRQ_MMC_BIT = 0;
    localparam int IRQ_MBC_BIT = 1;

endpackage

/* hw/sprite_regs.sv */
`timescale 1ns/1ps

module sprite_regs
    import sprite_pkg::*;
(
    input  logic         clk_dot4x,
    input  logic         rst,
    input  logic         psel_i,
    input  logic         penable_i,
    input  logic         pwrite_i,
    input  logic [7:0]   paddr_i,
    input  logic [31:0]  pwdata_i,
    input  sprite_mask_t m2m_set_i,
    input  sprite_mask_t m2d_set_i,
    input  logic         irq_mmc_req_i,
    input  logic         irq_mbc_req_i,
    output logic [31:0]  prdata_o,
    output logic         pready_o,
    output logic         pslverr_o,
    output sprite_xpos_t sprite_x_o [NUM_SPRITES],
    output sprite_mask_t sprite_en_o,
    output sprite_mask_t sprite_xe_o,
    output sprite_mask_t sprite_mmc_o,
    output logic         m2m_empty_o,
    output logic         m2d_empty_o,
    output logic         irq_mmc_o,
    output logic         irq_mbc_o
);

    logic [7:0]   x_lo [NUM_SPRITES];
    sprite_mask_t x_msb;
    sprite_mask_t m2m;
    sprite_mask_t m2d;
    logic [1:0]   irq_flags;
    logic [3:0]   reg_idx;
    logic         access;
    logic         bad_addr;
    logic         wr_en;
    logic         rd_en;
    logic         irq_clr_mmc;
    logic         irq_clr_mbc;

    assign reg_idx = paddr_i[5:2];
    assign access = psel_i && penable_i;

    // index 15, a set upper address bit or a misaligned address is unmapped
    assign bad_addr = (reg_idx > REG_IRQ) || (paddr_i[7:6] != 2'b00) || (paddr_i[1:0] != 2'b00);
    assign wr_en = access && pwrite_i && !bad_addr;
    assign rd_en = access && !pwrite_i && !bad_addr;

    // the slave never inserts wait states
    assign pready_o = access;
    assign pslverr_o = access && bad_addr;

    // write one to clear for each interrupt flag
    assign irq_clr_mmc = wr_en && (reg_idx == REG_IRQ) && pwdata_i[IRQ_MMC_BIT];
    assign irq_clr_mbc = wr_en && (reg_idx == REG_IRQ) && pwdata_i[IRQ_MBC_BIT];

    always_comb begin
        prdata_o = '0;
        if (rd_en) begin
            case (reg_idx)
                REG_X0, REG_X1, REG_X2, REG_X3,
                REG_X4, REG_X5, REG_X6, REG_X7: prdata_o = 32'(x_lo[reg_idx[2:0]]);
                REG_XMSB: prdata_o = 32'(x_msb);
                REG_EN:   prdata_o = 32'(sprite_en_o);
                REG_XE:   prdata_o = 32'(sprite_xe_o);
                REG_MMC:  prdata_o = 32'(sprite_mmc_o);
                REG_M2M:  prdata_o = 32'(m2m);
                REG_M2D:  prdata_o = 32'(m2d);
                REG_IRQ:  prdata_o = 32'(irq_flags);
                default:  prdata_o = '0;
            endcase
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int n = 0; n < NUM_SPRITES; n++) begin
                x_lo[n] <= '0;
            end
            x_msb <= '0;
            sprite_en_o <= '0;
            sprite_xe_o <= '0;
            sprite_mmc_o <= '0;
            m2m <= '0;
            m2d <= '0;
            irq_flags <= '0;
        end else begin
            // the collision and interrupt registers are not writable here
            if (wr_en) begin
                case (reg_idx)
                    REG_X0, REG_X1, REG_X2, REG_X3,
                    REG_X4, REG_X5, REG_X6, REG_X7: x_lo[reg_idx[2:0]] <= pwdata_i[7:0];
                    REG_XMSB: x_msb <= pwdata_i[NUM_SPRITES-1:0];
                    REG_EN:   sprite_en_o <= pwdata_i[NUM_SPRITES-1:0];
                    REG_XE:   sprite_xe_o <= pwdata_i[NUM_SPRITES-1:0];
                    REG_MMC:  sprite_mmc_o <= pwdata_i[NUM_SPRITES-1:0];
                    default:  ;
                endcase
            end

            // a read clears the latch but new collision bits of the same cycle survive
            m2m <= ((rd_en && reg_idx == REG_M2M) ? '0 : m2m) | m2m_set_i;
            m2d <= ((rd_en && reg_idx == REG_M2D) ? '0 : m2d) | m2d_set_i;

            // a request in the same cycle as a clear keeps the flag set
            irq_flags[IRQ_MMC_BIT] <= irq_mmc_req_i || (irq_flags[IRQ_MMC_BIT] && !irq_clr_mmc);
            irq_flags[IRQ_MBC_BIT] <= irq_mbc_req_i || (irq_flags[IRQ_MBC_BIT] && !irq_clr_mbc);
        end
    end

    // bit 8 of every x position lives in the shared msb register
    always_comb begin
        for (int n = 0; n < NUM_SPRITES; n++) begin
            sprite_x_o[n] = {x_msb[n], x_lo[n]};
        end
    end

    assign m2m_empty_o = (m2m == '0);
    assign m2d_empty_o = (m2d == '0);
    assign irq_mmc_o = irq_flags[IRQ_MMC_BIT];
    assign irq_mbc_o = irq_flags[IRQ_MBC_BIT];

endmodule

/* hw/sprite_shifter.sv */
`timescale 1ns/1ps

module sprite_shifter
    import sprite_pkg::*;
(
    input  logic           clk_dot4x,
    input  logic           rst,
    input  logic           dot_tick_i,
    input  sprite_xpos_t   xpos_i,
    input  logic           data_valid_i,
    input  logic [2:0]     data_sprite_i,
    input  logic [7:0]     data_byte_i,
    input  sprite_xpos_t   sprite_x_i [NUM_SPRITES],
    input  sprite_mask_t   sprite_en_i,
    input  sprite_mask_t   sprite_xe_i,
    input  sprite_mask_t   sprite_mmc_i,
    output sprite_pixels_t cur_pixels_o,
    output sprite_tag_t    cur_tag_o
);

    localparam int STEP_W = $clog2(SPRITE_BITS + 1);

    // the load register doubles as the shift register of each sprite
    logic [SPRITE_BITS-1:0] data [NUM_SPRITES];
    logic [SPRITE_BITS-1:0] nxt_data [NUM_SPRITES];
    logic [STEP_W-1:0]      step_cnt [NUM_SPRITES];
    logic [1:0]             hold [NUM_SPRITES];
    sprite_mask_t           active;
    sprite_mask_t           xe_ff;
    sprite_mask_t           mc_ff;
    sprite_mask_t           step_now;
    sprite_mask_t           done_now;
    sprite_pixels_t         nxt_pix;
    sprite_tag_t            nxt_tag;

    always_comb begin
        nxt_pix = '0;
        for (int n = 0; n < NUM_SPRITES; n++) begin
            // xe_ff is high on the first tick of each bit step
            step_now[n] = active[n] && xe_ff[n] && (step_cnt[n] != STEP_W'(SPRITE_BITS));
            done_now[n] = active[n] && xe_ff[n] && (step_cnt[n] == STEP_W'(SPRITE_BITS));
            if (step_now[n]) begin
                if (!sprite_mmc_i[n]) begin
                    nxt_pix[n] = {data[n][SPRITE_BITS-1], 1'b0};
                end else if (mc_ff[n]) begin
                    nxt_pix[n] = data[n][SPRITE_BITS-1 -: 2];
                end else begin
                    // second pixel of a multicolour pair repeats the latched code
                    nxt_pix[n] = hold[n];
                end
            end else if (active[n] && !done_now[n]) begin
                // second tick of an expanded step
                nxt_pix[n] = hold[n];
            end
        end
    end

    // the lowest numbered sprite with a visible code is the foremost one
    always_comb begin
        nxt_tag.mmc = sprite_mmc_i;
        nxt_tag.act_valid = 1'b0;
        nxt_tag.act_num = '0;
        for (int n = NUM_SPRITES - 1; n >= 0; n--) begin
            if (nxt_pix[n] != 2'b00) begin
                nxt_tag.act_valid = 1'b1;
                nxt_tag.act_num = 3'(n);
            end
        end
    end

    // a byte arriving in a shift cycle lands behind the shifted data
    always_comb begin
        for (int n = 0; n < NUM_SPRITES; n++) begin
            nxt_data[n] = data[n];
            if (dot_tick_i && step_now[n]) begin
                nxt_data[n] = {data[n][SPRITE_BITS-2:0], 1'b0};
            end
            if (data_valid_i && data_sprite_i == 3'(n)) begin
                nxt_data[n] = {nxt_data[n][SPRITE_BITS-9:0], data_byte_i};
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            active <= '0;
            xe_ff <= '0;
            mc_ff <= '0;
            cur_pixels_o <= '0;
            cur_tag_o <= '0;
            for (int n = 0; n < NUM_SPRITES; n++) begin
                data[n] <= '0;
                step_cnt[n] <= '0;
            end
        end else begin
            for (int n = 0; n < NUM_SPRITES; n++) begin
                data[n] <= nxt_data[n];
                if (dot_tick_i) begin
                    if (active[n]) begin
                        if (step_now[n]) begin
                            hold[n] <= nxt_pix[n];
                            step_cnt[n] <= step_cnt[n] + 1'b1;
                            if (sprite_mmc_i[n]) begin
                                mc_ff[n] <= !mc_ff[n];
                            end
                        end
                        if (done_now[n]) begin
                            active[n] <= 1'b0;
                        end
                        // with expansion every step takes two ticks
                        xe_ff[n] <= sprite_xe_i[n] ? !xe_ff[n] : 1'b1;
                    end else if (sprite_en_i[n] && sprite_x_i[n] == xpos_i) begin
                        // the first pixel follows on the next dot tick
                        active[n] <= 1'b1;
                        step_cnt[n] <= '0;
                        xe_ff[n] <= 1'b1;
                        mc_ff[n] <= 1'b1;
                    end
                end
            end
            if (dot_tick_i) begin
                cur_pixels_o <= nxt_pix;
                cur_tag_o <= nxt_tag;
            end
        end
    end

endmodule

/* hw/pixel_delay.sv */
`timescale 1ns/1ps

module pixel_delay #(
    parameter int  DEPTH = 6,
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk_dot4x,
    input  logic     rst,
    input  logic     dot_tick_i,
    input  payload_t data_i,
    output payload_t data_o
);

    // one register per dot tick of delay
    payload_t stages [DEPTH];

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= '0;
            end
        end else if (dot_tick_i) begin
            stages[0] <= data_i;
            // the chain only moves on pixel steps so it stays locked to the dot rate
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign data_o = stages[DEPTH-1];

endmodule

/* hw/sprite_collision.sv */
`timescale 1ns/1ps

module sprite_collision
    import sprite_pkg::*;
(
    input  logic           clk_dot4x,
    input  logic           rst,
    input  logic           dot_tick_i,
    input  sprite_pixels_t pixels_i,
    input  sprite_mask_t   mmc_i,
    input  logic           is_background_i,
    input  logic           main_border_i,
    input  logic           m2m_empty_i,
    input  logic           m2d_empty_i,
    output sprite_mask_t   m2m_set_o,
    output sprite_mask_t   m2d_set_o,
    output logic           irq_mmc_req_o,
    output logic           irq_mbc_req_o
);

    logic         prev_border;
    logic         border_rise;
    logic         mm_multi;
    sprite_mask_t mm_hit;
    sprite_mask_t md_hit;

    // the border is sampled every clock so a rise on the very last pixel is seen
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            prev_border <= 1'b0;
        end else begin
            prev_border <= main_border_i;
        end
    end

    // the last pixel before the border still collides with the background
    assign border_rise = main_border_i && !prev_border;

    always_comb begin
        for (int n = 0; n < NUM_SPRITES; n++) begin
            // sprite-sprite uses the top bit of the code in both modes
            mm_hit[n] = pixels_i[n][1];
            // a multicolour pixel is visible for any nonzero code
            md_hit[n] = (mmc_i[n] ? (pixels_i[n] != 2'b00) : pixels_i[n][1])
                && !is_background_i && (!main_border_i || border_rise);
        end
    end

    // clearing the lowest set bit leaves something only when two or more sprites overlap
    assign mm_multi = (mm_hit & (mm_hit - sprite_mask_t'(1))) != '0;

    assign m2m_set_o = (dot_tick_i && mm_multi) ? mm_hit : '0;
    assign m2d_set_o = dot_tick_i ? md_hit : '0;

    // an interrupt only fires for the first collision since the last clear
    assign irq_mmc_req_o = dot_tick_i && mm_multi && m2m_empty_i;
    assign irq_mbc_req_o = dot_tick_i && (md_hit != '0) && m2d_empty_i;

endmodule

/* hw/sprite_unit.sv */
`timescale 1ns/1ps

module sprite_unit
    import sprite_pkg::*;
#(
    parameter int DELAY_DEPTH = 6
) (
    input  logic           clk_dot4x,
    input  logic           rst,
    input  logic           psel_i,
    input  logic           penable_i,
    input  logic           pwrite_i,
    input  logic [7:0]     paddr_i,
    input  logic [31:0]    pwdata_i,
    output logic [31:0]    prdata_o,
    output logic           pready_o,
    output logic           pslverr_o,
    input  logic           dot_tick_i,
    input  sprite_xpos_t   xpos_i,
    input  logic           data_valid_i,
    input  logic [2:0]     data_sprite_i,
    input  logic [7:0]     data_byte_i,
    input  logic           is_background_i,
    input  logic           main_border_i,
    output sprite_pixels_t sprite_pixels_o,
    output sprite_mask_t   sprite_mmc_o,
    output logic [3:0]     active_sprite_o,
    output logic           irq_mmc_o,
    output logic           irq_mbc_o
);

    sprite_xpos_t   sprite_x [NUM_SPRITES];
    sprite_mask_t   sprite_en;
    sprite_mask_t   sprite_xe;
    sprite_mask_t   sprite_mmc;
    sprite_mask_t   m2m_set;
    sprite_mask_t   m2d_set;
    logic           m2m_empty;
    logic           m2d_empty;
    logic           irq_mmc_req;
    logic           irq_mbc_req;
    sprite_pixels_t cur_pixels;
    sprite_tag_t    cur_tag;
    sprite_tag_t    tag_d;

    sprite_regs sprite_regs_inst (
        .clk_dot4x(clk_dot4x), .rst(rst),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i),
        .m2m_set_i(m2m_set), .m2d_set_i(m2d_set),
        .irq_mmc_req_i(irq_mmc_req), .irq_mbc_req_i(irq_mbc_req),
        .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
        .sprite_x_o(sprite_x), .sprite_en_o(sprite_en), .sprite_xe_o(sprite_xe),
        .sprite_mmc_o(sprite_mmc), .m2m_empty_o(m2m_empty), .m2d_empty_o(m2d_empty),
        .irq_mmc_o(irq_mmc_o), .irq_mbc_o(irq_mbc_o)
    );

    sprite_shifter sprite_shifter_inst (
        .clk_dot4x(clk_dot4x), .rst(rst), .dot_tick_i(dot_tick_i), .xpos_i(xpos_i),
        .data_valid_i(data_valid_i), .data_sprite_i(data_sprite_i), .data_byte_i(data_byte_i),
        .sprite_x_i(sprite_x), .sprite_en_i(sprite_en), .sprite_xe_i(sprite_xe),
        .sprite_mmc_i(sprite_mmc), .cur_pixels_o(cur_pixels), .cur_tag_o(cur_tag)
    );

    // pixels and their tags share the same depth so they stay paired
    pixel_delay #(.DEPTH(DELAY_DEPTH), .payload_t(sprite_pixels_t)) pixel_delay_pix (
        .clk_dot4x(clk_dot4x), .rst(rst), .dot_tick_i(dot_tick_i),
        .data_i(cur_pixels), .data_o(sprite_pixels_o)
    );

    pixel_delay #(.DEPTH(DELAY_DEPTH), .payload_t(sprite_tag_t)) pixel_delay_tag (
        .clk_dot4x(clk_dot4x), .rst(rst), .dot_tick_i(dot_tick_i),
        .data_i(cur_tag), .data_o(tag_d)
    );

    sprite_collision sprite_collision_inst (
        .clk_dot4x(clk_dot4x), .rst(rst), .dot_tick_i(dot_tick_i),
        .pixels_i(sprite_pixels_o), .mmc_i(tag_d.mmc),
        .is_background_i(is_background_i), .main_border_i(main_border_i),
        .m2m_empty_i(m2m_empty), .m2d_empty_i(m2d_empty),
        .m2m_set_o(m2m_set), .m2d_set_o(m2d_set),
        .irq_mmc_req_o(irq_mmc_req), .irq_mbc_req_o(irq_mbc_req)
    );

    assign sprite_mmc_o = tag_d.mmc;
    assign active_sprite_o = {tag_d.act_valid, tag_d.act_num};

endmodule

/* dv/sprite_unit_tb.sv */
`timescale 1ns/1ps

module sprite_unit_tb
    import sprite_pkg::*;
;

    localparam int DELAY_DEPTH = 6;

    logic clk_dot4x;
    logic rst;
    logic psel_i, penable_i, pwrite_i;
    logic [7:0] paddr_i;
    logic [31:0] pwdata_i, prdata_o;
    logic pready_o, pslverr_o;
    logic dot_tick_i;
    sprite_xpos_t xpos_i;
    logic data_valid_i;
    logic [2:0] data_sprite_i;
    logic [7:0] data_byte_i;
    logic is_background_i, main_border_i;
    sprite_pixels_t sprite_pixels_o;
    sprite_mask_t sprite_mmc_o;
    logic [3:0] active_sprite_o;
    logic irq_mmc_o, irq_mbc_o;

    integer seed;
    int errors, timeouts, checks;
    int border_hits;
    logic [1:0] tick_cnt;
    logic rand_env;
    logic env_on, env_bg, env_flip;

    // register shadows change at the edge that ends each write and the model sees them from the next clock on
    logic [7:0] w_xlo [NUM_SPRITES];
    sprite_mask_t w_xmsb, w_en, w_xe, w_mmc;

    // reference model state
    logic [SPRITE_BITS-1:0] m_data [NUM_SPRITES];
    int m_cnt [NUM_SPRITES];
    sprite_mask_t m_active, m_fired, m_m2m, m_m2d;
    logic m_irq_mmc, m_irq_mbc, m_prev_border;
    sprite_pixels_t pipe_pix [DELAY_DEPTH+1];
    sprite_tag_t pipe_tag [DELAY_DEPTH+1];

    sprite_unit #(.DELAY_DEPTH(DELAY_DEPTH)) sprite_unit_inst (.*);

    always #2 clk_dot4x = !clk_dot4x;

    // random background and border values are drawn halfway between rising edges
    always @(negedge clk_dot4x) begin
        env_on = rand_env;
        if (rand_env) begin
            env_bg = 1'($random(seed));
            env_flip = (($random(seed) & 3) == 0);
        end
    end

    // a dot tick comes every fourth clock and x advances after each tick
    always @(posedge clk_dot4x) begin
        if (rst) begin
            tick_cnt <= 2'd0;
            dot_tick_i <= 1'b0;
            xpos_i <= '0;
        end else begin
            tick_cnt <= tick_cnt + 2'd1;
            dot_tick_i <= (tick_cnt == 2'd3);
            if (dot_tick_i) begin
                xpos_i <= xpos_i + 9'd1;
            end
        end
        if (env_on) begin
            is_background_i <= env_bg;
            // toggling the border now and then gives runs with rising edges
            main_border_i <= main_border_i ^ env_flip;
        end else begin
            is_background_i <= 1'b1;
            main_border_i <= 1'b0;
        end
    end

    always @(posedge clk_dot4x) begin : model
        sprite_pixels_t pix;
        sprite_tag_t tag;
        sprite_mask_t mm, md;
        logic vis;
        int len, step;
        if (rst) begin
            m_active = '0;
            m_m2m = '0;
            m_m2d = '0;
            m_irq_mmc = 1'b0;
            m_irq_mbc = 1'b0;
            m_prev_border = 1'b0;
            for (int i = 0; i <= DELAY_DEPTH; i++) begin
                pipe_pix[i] = '0;
                pipe_tag[i] = '0;
            end
        end else begin
            if (dot_tick_i) begin
                // collisions look at the pixel leaving the delay line
                for (int n = 0; n < NUM_SPRITES; n++) begin
                    mm[n] = pipe_pix[DELAY_DEPTH][n][1];
                    vis = pipe_tag[DELAY_DEPTH].mmc[n] ? (pipe_pix[DELAY_DEPTH][n] != 2'b00)
                                                       : pipe_pix[DELAY_DEPTH][n][1];
                    md[n] = vis && !is_background_i && (!main_border_i || !m_prev_border);
                end
                // a background hit while the border is high can only come from its rising edge
                if (main_border_i && md != '0) border_hits++;
                if ($countones(mm) >= 2) begin
                    if (m_m2m == '0) m_irq_mmc = 1'b1;
                    m_m2m = m_m2m | mm;
                end
                if (md != '0) begin
                    if (m_m2d == '0) m_irq_mbc = 1'b1;
                    m_m2d = m_m2d | md;
                end
                for (int n = 0; n < NUM_SPRITES; n++) begin
                    pix[n] = 2'b00;
                    if (m_active[n]) begin
                        len = w_xe[n] ? 2 * SPRITE_BITS : SPRITE_BITS;
                        if (m_cnt[n] == len) begin
                            m_active[n] = 1'b0;
                            m_fired[n] = 1'b1;
                            m_data[n] = '0;
                        end else begin
                            step = w_xe[n] ? m_cnt[n] / 2 : m_cnt[n];
                            if (w_mmc[n]) begin
                                pix[n] = m_data[n][SPRITE_BITS-1-2*(step/2) -: 2];
                            end else begin
                                pix[n] = {m_data[n][SPRITE_BITS-1-step], 1'b0};
                            end
                            m_cnt[n] = m_cnt[n] + 1;
                        end
                    end else if (w_en[n] && {w_xmsb[n], w_xlo[n]} == xpos_i) begin
                        m_active[n] = 1'b1;
                        m_cnt[n] = 0;
                    end
                end
                tag.mmc = w_mmc;
                tag.act_valid = 1'b0;
                tag.act_num = 3'd0;
                // the first visible sprite found from sprite 0 upward is in front
                for (int n = 0; n < NUM_SPRITES; n++) begin
                    if (!tag.act_valid && pix[n] != 2'b00) begin
                        tag.act_valid = 1'b1;
                        tag.act_num = 3'(n);
                    end
                end
                for (int i = DELAY_DEPTH; i > 0; i--) begin
                    pipe_pix[i] = pipe_pix[i-1];
                    pipe_tag[i] = pipe_tag[i-1];
                end
                pipe_pix[0] = pix;
                pipe_tag[0] = tag;
            end
            m_prev_border = main_border_i;
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk_dot4x) begin
        if (!rst) begin
            check_value(32'(sprite_pixels_o), 32'(pipe_pix[DELAY_DEPTH]), "sprite pixels");
            check_value(32'(sprite_mmc_o), 32'(pipe_tag[DELAY_DEPTH].mmc), "pixel mmc mask");
            check_value(32'(active_sprite_o),
                        32'({pipe_tag[DELAY_DEPTH].act_valid, pipe_tag[DELAY_DEPTH].act_num}),
                        "foremost sprite");
            check_value(32'(irq_mmc_o), 32'(m_irq_mmc), "sprite-sprite irq");
            check_value(32'(irq_mbc_o), 32'(m_irq_mbc), "sprite-background irq");
        end
    end

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int waits;
        waits = 0;
        @(posedge clk_dot4x);
        psel_i <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i <= wr;
        paddr_i <= addr;
        pwdata_i <= wdata;
        @(posedge clk_dot4x);
        penable_i <= 1'b1;
        @(negedge clk_dot4x);
        while (!pready_o && waits < 16) begin
            waits++;
            @(negedge clk_dot4x);
        end
        if (!pready_o) begin
            timeouts++;
            $display("Error: APB access to address %h got no ready", addr);
        end
        rdata = prdata_o;
        err = pslverr_o;
        // the access ends at this edge
        @(posedge clk_dot4x);
        psel_i <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i <= 1'b0;
    endtask

    task automatic reg_write(input logic [3:0] idx, input logic [31:0] data);
        logic [31:0] rd;
        logic err;
        apb_access(1'b1, {2'b00, idx, 2'b00}, data, rd, err);
        check_value(32'(err), 32'd0, "slave error on write");
        if (idx <= REG_X7) w_xlo[idx[2:0]] <= data[7:0];
        if (idx == REG_XMSB) w_xmsb <= data[7:0];
        if (idx == REG_EN) w_en <= data[7:0];
        if (idx == REG_XE) w_xe <= data[7:0];
        if (idx == REG_MMC) w_mmc <= data[7:0];
    endtask

    task automatic reg_read(input logic [3:0] idx, output logic [31:0] data);
        logic err;
        apb_access(1'b0, {2'b00, idx, 2'b00}, 32'd0, data, err);
        check_value(32'(err), 32'd0, "slave error on read");
    endtask

    task automatic load_sprite(input int n, input logic [SPRITE_BITS-1:0] pat);
        m_data[n] = pat;
        for (int b = 2; b >= 0; b--) begin
            @(posedge clk_dot4x);
            data_valid_i <= 1'b1;
            data_sprite_i <= 3'(n);
            data_byte_i <= pat[8*b +: 8];
        end
        @(posedge clk_dot4x);
        data_valid_i <= 1'b0;
    endtask

    function automatic logic is_idle(input sprite_mask_t mask);
        logic empty;
        empty = 1'b1;
        for (int i = 0; i <= DELAY_DEPTH; i++) begin
            if (pipe_pix[i] != '0) empty = 1'b0;
        end
        return empty && ((m_fired & mask) == mask) && (m_active == '0);
    endfunction

    task automatic wait_idle(input sprite_mask_t mask);
        int cnt;
        cnt = 0;
        @(negedge clk_dot4x);
        while (!is_idle(mask) && cnt < 20000) begin
            cnt++;
            @(negedge clk_dot4x);
        end
        if (!is_idle(mask)) begin
            timeouts++;
            $display("Error: sprites %b did not finish their line in time", mask);
        end
    endtask

    // place the chosen sprites inside a window of x positions and let them run one line
    task automatic run_round(input sprite_mask_t en, input sprite_mask_t mmc,
                             input sprite_mask_t xe, input int window);
        logic [8:0] base;
        logic [8:0] xv;
        sprite_mask_t msb;
        msb = '0;
        base = 9'($random(seed));
        for (int n = 0; n < NUM_SPRITES; n++) begin
            if (en[n]) begin
                load_sprite(n, 24'($random(seed)));
                xv = base + 9'($unsigned($random(seed)) % window);
                reg_write(4'(n), 32'(xv[7:0]));
                msb[n] = xv[8];
            end
        end
        reg_write(REG_XMSB, 32'(msb));
        reg_write(REG_MMC, 32'(mmc));
        reg_write(REG_XE, 32'(xe));
        m_fired = '0;
        reg_write(REG_EN, 32'(en));
        wait_idle(en);
        reg_write(REG_EN, 32'd0);
    endtask

    task automatic read_and_clear_collisions();
        logic [31:0] d;
        reg_read(REG_M2M, d);
        check_value(d, 32'(m_m2m), "m2m register");
        m_m2m = '0;
        reg_read(REG_M2D, d);
        check_value(d, 32'(m_m2d), "m2d register");
        m_m2d = '0;
        reg_read(REG_IRQ, d);
        check_value(d, {30'd0, m_irq_mbc, m_irq_mmc}, "irq register");
        reg_write(REG_IRQ, 32'd3);
        m_irq_mmc = 1'b0;
        m_irq_mbc = 1'b0;
    endtask

    initial begin : main
        logic [31:0] exp_val [12];
        logic [31:0] d;
        logic err;
        seed = 32'hf1aa427c;
        clk_dot4x = 1'b0;
        rst = 1'b1;
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        paddr_i = '0;
        pwdata_i = '0;
        dot_tick_i = 1'b0;
        xpos_i = '0;
        data_valid_i = 1'b0;
        data_sprite_i = '0;
        data_byte_i = '0;
        is_background_i = 1'b1;
        main_border_i = 1'b0;
        rand_env = 1'b0;
        env_on = 1'b0;
        env_bg = 1'b1;
        env_flip = 1'b0;
        errors = 0;
        timeouts = 0;
        checks = 0;
        border_hits = 0;
        w_xmsb = '0;
        w_en = '0;
        w_xe = '0;
        w_mmc = '0;
        m_fired = '0;
        for (int n = 0; n < NUM_SPRITES; n++) begin
            w_xlo[n] = '0;
            m_data[n] = '0;
            m_cnt[n] = 0;
        end
        repeat (4) @(posedge clk_dot4x);
        rst <= 1'b0;

        // register access with random values, then unmapped addresses
        // the masks go in before the enable so no sprite sees its mode change mid line
        for (int i = 11; i >= 0; i--) begin
            exp_val[i] = 32'($random(seed) & 32'hff);
            reg_write(4'(i), exp_val[i]);
        end
        for (int i = 0; i < 12; i++) begin
            reg_read(4'(i), d);
            check_value(d, exp_val[i], "register readback");
        end
        apb_access(1'b1, 8'h3c, 32'hff, d, err);
        check_value(32'(err), 32'd1, "slave error for index 15");
        apb_access(1'b1, 8'h01, 32'h5a, d, err);
        check_value(32'(err), 32'd1, "slave error for misaligned address");
        apb_access(1'b0, 8'h40, 32'd0, d, err);
        check_value(32'(err), 32'd1, "slave error for high address");
        for (int i = 0; i < 12; i++) begin
            reg_read(4'(i), d);
            check_value(d, exp_val[i], "register after unmapped accesses");
        end
        reg_write(REG_EN, 32'd0);
        wait_idle('0);
        read_and_clear_collisions();

        // single colour, one sprite, no expansion
        for (int r = 0; r < 4; r++) begin
            run_round(sprite_mask_t'(1 << ($unsigned($random(seed)) % 8)), '0, '0, 8);
            read_and_clear_collisions();
        end

        // random multicolour and expansion masks with overlapping sprites
        for (int r = 0; r < 6; r++) begin
            run_round(8'($random(seed)), 8'($random(seed)), 8'($random(seed)), 24);
            read_and_clear_collisions();
        end

        // all sprites stacked closely so they must collide with each other
        run_round(8'hff, '0, '0, 6);
        check_value(32'(m_m2m != '0), 32'd1, "overlap produced a sprite collision");
        check_value(32'(m_irq_mmc), 32'd1, "sprite-sprite irq raised");
        reg_read(REG_M2M, d);
        check_value(d, 32'(m_m2m), "m2m after overlap");
        m_m2m = '0;
        reg_read(REG_M2M, d);
        check_value(d, 32'd0, "m2m cleared by read");
        reg_write(REG_IRQ, 32'd1);
        m_irq_mmc = 1'b0;
        read_and_clear_collisions();

        // background and border driven randomly every clock
        for (int r = 0; r < 4; r++) begin
            rand_env = 1'b1;
            run_round(8'($random(seed)) | 8'h01, 8'($random(seed)), 8'($random(seed)), 32);
            rand_env = 1'b0;
            repeat (4) @(posedge clk_dot4x);
            read_and_clear_collisions();
        end
        check_value(32'(border_hits != 0), 32'd1, "collision on a rising border");

        $display("Checks: %0d, mismatches: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* files.f */
hw/sprite_pkg.sv
hw/sprite_regs.sv
hw/sprite_shifter.sv
hw/pixel_delay.sv
hw/sprite_collision.sv
hw/sprite_unit.sv
dv/sprite_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= sprite_unit_tb
RTL_TOP ?= sprite_unit
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal
PASS_MSG ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed" && exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only hw/sprite_pkg.sv hw/sprite_regs.sv hw/sprite_shifter.sv \
		hw/pixel_delay.sv hw/sprite_collision.sv hw/sprite_unit.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
